// File: cam_cfg_pkg.sv
package cam_cfg_pkg;

    // One table word is a 16-bit sensor register address followed by its 8-bit value
    typedef logic [15:0] cfg_addr_t;        // Sensor register address
    typedef logic [7:0]  cfg_val_t;         // Sensor register value

    // Full word as sent to the bus master, address in the upper bits
    typedef logic [$bits(cfg_addr_t)+$bits(cfg_val_t)-1:0] cfg_word_t;

    typedef logic [7:0]  cfg_index_t;       // Table position, reaches one past the end
    typedef logic [14:0] wait_cnt_t;        // Power-up settling counter

    // Table size, fixed by the contents of the hex file
    localparam cfg_index_t CFG_REG_NUM    = 8'd128;             // Entries in the table
    localparam cfg_index_t CFG_LAST_INDEX = CFG_REG_NUM - 8'd1; // Final entry position
    localparam int         CFG_ROM_AW     = $clog2(CFG_REG_NUM); // ROM word address bits

    // Settling time after reset before the first register write
    localparam wait_cnt_t  CFG_WAIT_CYCLES = 15'd30000;              // Cycles to wait
    localparam wait_cnt_t  CFG_WAIT_LAST   = CFG_WAIT_CYCLES - 15'd1; // Final wait count

    // Hex image of the table, one 6-digit word per line in issue order
    localparam CFG_TABLE_FILE = "cam_cfg_table.hex";

    // Sequencer states
    typedef enum logic [1:0] {
        ST_WAIT,                            // Power-up settling
        ST_ISSUE,                           // Start pulse for the entry on offer
        ST_BUSY,                            // Bus master is writing the entry
        ST_DONE                             // Table finished, stays here until reset
    } cfg_state_t;

endpackage

// File: cam_cfg_rom.sv
`timescale 1ns/1ps

// Configuration table of the sensor
// Words are {register address, register value}, e.g. 24'h310311 writes 0x11 to 0x3103
module cam_cfg_rom
    import cam_cfg_pkg::*;
(
    input  cfg_index_t cfg_index,           // Entry requested by the sequencer
    output cfg_word_t  cfg_data             // Word at that entry, zero past the end
);

    cfg_word_t              rom_mem [0:CFG_REG_NUM-1]; // Table contents
    logic [CFG_ROM_AW-1:0]  rom_addr;                  // Word address inside the table
    logic                   in_table;                  // Index lies within the table

    // Contents fixed at elaboration
    initial begin
        $readmemh(CFG_TABLE_FILE, rom_mem);
    end

    assign rom_addr = cfg_index[CFG_ROM_AW-1:0];       // Upper index bit only marks the end
    assign in_table = (cfg_index < CFG_REG_NUM);       // 0 .. CFG_REG_NUM-1

    // Pure lookup, no clock and no latency
    // The index reaches CFG_REG_NUM once the last entry is written,
    // and the bus then sees an all-zero word
    always_comb begin
        if (in_table) begin
            cfg_data = rom_mem[rom_addr];              // Stored word
        end else begin
            cfg_data = '0;                             // Past the end
        end
    end

endmodule

// File: cam_cfg_seq.sv
`timescale 1ns/1ps

// Power-up sequencer of the register loader
// Waits the settling time, then hands the table entries one by one to the bus master
module cam_cfg_seq
    import cam_cfg_pkg::*;
(
    input  logic       sys_clk,             // System clock
    input  logic       sys_rst_n,           // Asynchronous reset, active low
    input  logic       cfg_end,             // Bus master finished the entry on offer
    output logic       cfg_start,           // One-cycle start towards the bus master
    output logic       cfg_done,            // All entries written, sticky until reset
    output cfg_index_t cfg_index            // Entry on offer, drives the table lookup
);

    cfg_state_t state;                      // Current state
    cfg_state_t state_nxt;                  // Next state
    wait_cnt_t  wait_cnt;                   // Settling counter
    logic       wait_over;                  // Final settling cycle
    logic       last_entry;                 // Entry on offer is the final one
    logic       entry_ack;                  // End pulse for an outstanding entry

    assign wait_over  = (wait_cnt == CFG_WAIT_LAST);      // Counted 0 .. CFG_WAIT_CYCLES-1
    assign last_entry = (cfg_index == CFG_LAST_INDEX);    // Table position 127
    assign entry_ack  = (state == ST_BUSY) && cfg_end;    // Only counts while an entry is out

    // Start pulse is a state decode, so it lasts exactly the one ISSUE cycle
    assign cfg_start = (state == ST_ISSUE);

    // Next-state decode
    always_comb begin
        state_nxt = state;                  // Hold by default
        case (state)
            ST_WAIT: begin
                if (wait_over) begin
                    state_nxt = ST_ISSUE;   // Settled, offer entry 0
                end
            end
            ST_ISSUE: begin
                state_nxt = ST_BUSY;        // Master needs at least a cycle to answer
            end
            ST_BUSY: begin
                if (entry_ack && last_entry) begin
                    state_nxt = ST_DONE;    // Table finished
                end else if (entry_ack) begin
                    state_nxt = ST_ISSUE;   // Next entry, start one cycle after the end
                end
            end
            ST_DONE: begin
                state_nxt = ST_DONE;        // Late end pulses have no effect
            end
            default: begin
                state_nxt = ST_WAIT;
            end
        endcase
    end

    // State register
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state <= ST_WAIT;
        end else begin
            state <= state_nxt;
        end
    end

    // Settling counter
    // Stops at its final value; the first start then rises
    // on the CFG_WAIT_CYCLES-th rising edge after reset release
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wait_cnt <= '0;
        end else if ((state == ST_WAIT) && !wait_over) begin
            wait_cnt <= wait_cnt + 1'b1;    // Count while settling
        end
    end

    // Entry index, held steady while the master is busy so cfg_data stays put
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            cfg_index <= '0;
        end else if (entry_ack) begin
            cfg_index <= cfg_index + 1'b1;  // Last entry steps to CFG_REG_NUM
        end
    end

    // Done flag, set on the same edge the index moves past the table
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            cfg_done <= 1'b0;
        end else if (entry_ack && last_entry) begin
            cfg_done <= 1'b1;               // Sticky until the next reset
        end
    end

endmodule

// File: ov5640_cfg.sv
`timescale 1ns/1ps

// OV5640 power-up register loader
// Feeds {address, value} words to an external serial-bus master, one per start pulse
module ov5640_cfg
    import cam_cfg_pkg::*;
(
    input  logic      sys_clk,              // System clock
    input  logic      sys_rst_n,            // Asynchronous reset, active low
    input  logic      cfg_end,              // Bus master finished one register write
    output logic      cfg_start,            // Start one register write
    output cfg_word_t cfg_data,             // {register address, register value}
    output logic      cfg_done              // Whole table written
);

    cfg_index_t cfg_index;                  // Entry on offer, sequencer to table

    // Sequencing, pulse exchange and completion
    cam_cfg_seq u_seq (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .cfg_end   (cfg_end),
        .cfg_start (cfg_start),
        .cfg_done  (cfg_done),
        .cfg_index (cfg_index)
    );

    // Word lookup, valid in the same cycle as the index
    cam_cfg_rom u_rom (
        .cfg_index (cfg_index),
        .cfg_data  (cfg_data)
    );

endmodule

// File: tb_sccb_responder.sv
`timescale 1ns/1ps

// Model of the serial-bus master
// Answers each start with one end pulse after a random number of cycles
module tb_sccb_responder
    import cam_cfg_pkg::*;
#(
    parameter int SEED      = 9,            // Start value of the random sequence
    parameter int DELAY_MIN = 1,            // Shortest answer, cycles after the start
    parameter int DELAY_MAX = 20,           // Longest answer
    parameter int DRIVE_DLY = 1             // Output skew after the rising edge, ns
)
(
    input  logic sys_clk,                   // System clock
    input  logic sys_rst_n,                 // Reset of the loader, active low
    input  logic cfg_start,                 // Start of one register write
    input  logic stray_req,                 // Request for one unsolicited end pulse
    output logic cfg_end                    // End of the register write
);

    int   seed;                             // Random state
    int   delay_cnt;                        // Cycles left until the end pulse
    logic pending;                          // A write is in flight
    logic start_seen;                       // cfg_start of the cycle just ended
    logic stray_seen;                       // stray_req of the cycle just ended
    logic rst_seen;                         // sys_rst_n of the cycle just ended
    logic end_nxt;                          // End pulse for the coming cycle

    initial begin
        seed      = SEED;
        delay_cnt = 0;
        pending   = 1'b0;
        cfg_end   = 1'b0;
    end

    // Answer time of one write, DELAY_MIN .. DELAY_MAX
    function automatic int draw_delay();
        int span;
        span = DELAY_MAX - DELAY_MIN + 1;
        return DELAY_MIN + int'({$random(seed)} % span);
    endfunction

    always begin
        @(posedge sys_clk);
        start_seen = cfg_start;             // Sampled before the DUT moves on
        stray_seen = stray_req;
        rst_seen   = sys_rst_n;
        #DRIVE_DLY;
        end_nxt = 1'b0;
        if (!rst_seen) begin
            pending   = 1'b0;               // Reset drops a write in flight
            delay_cnt = 0;
        end else begin
            if (start_seen) begin
                delay_cnt = draw_delay();   // New write accepted
                pending   = 1'b1;
            end
            if (pending) begin
                delay_cnt = delay_cnt - 1;
                if (delay_cnt == 0) begin
                    end_nxt = 1'b1;         // Write finished
                    pending = 1'b0;
                end
            end else if (stray_seen) begin
                end_nxt = 1'b1;             // Unsolicited end, nothing outstanding
            end
        end
        cfg_end = end_nxt;
    end

endmodule

// File: tb_ov5640_cfg.sv
`timescale 1ns/1ps

// Testbench of the OV5640 register loader
// The responder plays the bus master and the checker follows every output cycle by cycle
module tb_ov5640_cfg
    import cam_cfg_pkg::*;
();

    localparam int CLK_HALF       = 4;      // 8 ns clock period
    localparam int DRIVE_DLY      = 1;      // Input skew after the rising edge
    localparam int RESET_CYCLES   = 10;
    localparam int SEED           = 9;      // Responder random seed
    localparam int DELAY_MIN      = 1;      // Responder answer time bounds
    localparam int DELAY_MAX      = 20;
    localparam int STRAY_AT       = 100;    // Unsolicited end this far into the wait
    localparam int TAIL_CYCLES    = 20;     // Idle cycles after completion
    localparam int STRAY_TOTAL    = 4;      // Two per run
    // Two full runs with each entry at most 23 cycles
    localparam int TIMEOUT_CYCLES = 2 * (int'(CFG_WAIT_CYCLES) + int'(CFG_REG_NUM) * 23);

    logic      sys_clk;
    logic      sys_rst_n;
    logic      cfg_end;                     // From the responder
    logic      stray_req;                   // One-shot request to the responder
    logic      cfg_start;
    cfg_word_t cfg_data;
    logic      cfg_done;

    cfg_word_t ref_table [0:CFG_REG_NUM-1]; // Expected words in issue order

    int   run_cyc;                          // Cycles since reset release
    int   start_cnt;                        // Starts seen in this run
    logic outstanding;                      // Entry handed out, no end yet
    logic end_prev;                         // Previous cycle acknowledged an entry
    logic start_prev;                       // cfg_start of the previous cycle
    logic done_exp;                         // Expected cfg_done
    int   stray_cnt;                        // End pulses with nothing outstanding
    int   cyc_cnt;                          // Cycles since time zero

    ov5640_cfg u_dut (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .cfg_end   (cfg_end),
        .cfg_start (cfg_start),
        .cfg_data  (cfg_data),
        .cfg_done  (cfg_done)
    );

    tb_sccb_responder #(
        .SEED      (SEED),
        .DELAY_MIN (DELAY_MIN),
        .DELAY_MAX (DELAY_MAX),
        .DRIVE_DLY (DRIVE_DLY)
    ) u_responder (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .cfg_start (cfg_start),
        .stray_req (stray_req),
        .cfg_end   (cfg_end)
    );

    always begin
        #CLK_HALF;
        sys_clk = ~sys_clk;
    end

    // Expected word on offer for a given entry or zero past the table
    function automatic cfg_word_t ref_word(input int entry);
        if (entry >= 0 && entry < CFG_REG_NUM) begin
            return ref_table[entry];
        end else begin
            return '0;
        end
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Checker runs mid-cycle where every signal is settled
    always @(negedge sys_clk) begin
        if (!sys_rst_n) begin
            check_equal(cfg_start, 1'b0, "cfg_start high during reset");
            check_equal(cfg_done, 1'b0, "cfg_done high during reset");
            check_equal(cfg_data, ref_word(0), "cfg_data during reset");
            run_cyc     = 0;
            start_cnt   = 0;
            outstanding = 1'b0;
            end_prev    = 1'b0;
            start_prev  = 1'b0;
            done_exp    = 1'b0;
        end else begin
            check_equal(cfg_done, done_exp, "cfg_done");
            // Held entry while outstanding, otherwise the next one (zero after the last)
            check_equal(cfg_data, outstanding ? ref_word(start_cnt - 1) : ref_word(start_cnt),
                        "cfg_data");
            if (cfg_start) begin
                check_equal(start_prev, 1'b0, "cfg_start longer than one cycle");
                check_equal(outstanding, 1'b0, "cfg_start while an entry is outstanding");
                check_equal(start_cnt < CFG_REG_NUM, 1'b1, "cfg_start beyond the last entry");
                if (start_cnt == 0) begin
                    // Start rises on the CFG_WAIT_CYCLES-th edge after release
                    check_equal(run_cyc, CFG_WAIT_CYCLES, "cycle of the first cfg_start");
                end
                outstanding = 1'b1;
                start_cnt   = start_cnt + 1;
            end else begin
                check_equal(start_cnt == 0 && run_cyc >= CFG_WAIT_CYCLES, 1'b0,
                            "first cfg_start missing after the wait");
                check_equal(end_prev && start_cnt < CFG_REG_NUM, 1'b0,
                            "no cfg_start one cycle after cfg_end");
            end
            end_prev = 1'b0;
            if (cfg_end && outstanding && !cfg_start) begin
                outstanding = 1'b0;         // Entry acknowledged
                end_prev    = 1'b1;
                if (start_cnt == CFG_REG_NUM) begin
                    done_exp = 1'b1;        // Last entry so done from the next cycle
                end
            end else if (cfg_end) begin
                stray_cnt = stray_cnt + 1;  // Must be ignored by the DUT
            end
            start_prev = cfg_start;
            run_cyc    = run_cyc + 1;
        end
    end

    // Watchdog
    always @(posedge sys_clk) begin
        cyc_cnt = cyc_cnt + 1;
        if (cyc_cnt > TIMEOUT_CYCLES) begin
            $display("Timeout: the loader did not finish within %0d clock cycles",
                     TIMEOUT_CYCLES);
            $display("Simulation failed");
            $fatal(1, "Run aborted by the cycle limit");
        end
    end

    // Holds reset for RESET_CYCLES edges, then releases it
    task automatic release_reset();
        repeat (RESET_CYCLES) @(posedge sys_clk);
        #DRIVE_DLY;
        sys_rst_n = 1'b1;
    endtask

    task automatic restart_with_reset();
        @(posedge sys_clk);
        #DRIVE_DLY;
        sys_rst_n = 1'b0;                   // Clears cfg_done
        release_reset();
    endtask

    task automatic send_stray_end();
        @(posedge sys_clk);
        #DRIVE_DLY;
        stray_req = 1'b1;
        @(posedge sys_clk);
        #DRIVE_DLY;
        stray_req = 1'b0;
    endtask

    task automatic wait_for_done();
        while (cfg_done !== 1'b1) begin
            @(posedge sys_clk);
        end
    endtask

    // One full table load with an unsolicited end in the wait and one after completion
    task automatic run_sequence();
        repeat (STRAY_AT) @(posedge sys_clk);
        send_stray_end();
        wait_for_done();
        send_stray_end();
        repeat (TAIL_CYCLES) @(posedge sys_clk);
    endtask

    initial begin
        sys_clk   = 1'b0;
        sys_rst_n = 1'b0;
        stray_req = 1'b0;
        stray_cnt = 0;
        cyc_cnt   = 0;
        $readmemh(CFG_TABLE_FILE, ref_table);
        release_reset();
        run_sequence();                     // Power-up run
        restart_with_reset();
        run_sequence();                     // Run after a reset from the done state
        check_equal(stray_cnt, STRAY_TOTAL, "unsolicited cfg_end pulses sent");
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: cam_cfg_table.hex
// One 24-bit word per line, 4 hex digits register address then 2 hex digits value
// Lines in issue order, entry 0 first
300802
310302
3017ff
3018ff
303713
310801
363036
36310e
3632e2
363312
3621e0
3704a0
37035a
371578
371701
370b60
37051a
390502
390610
39010a
373112
360008
360133
302d60
362052
371b20
471c50
3a1343
3a1800
3a19f8
363513
363603
363440
362201
3c0134
3c0428
3c0598
3c0600
3c0708
3c0800
3c091c
3c0a9c
3c0b40
382046
382101
381431
381531
380000
380100
380200
380304
38040a
38053f
380607
38079b
380802
380980
380a01
380be0
380c07
380d68
380e03
380fd8
381306
361800
361229
370864
370952
370c03
3a0203
3a03d8
3a0801
3a0927
3a0a00
3a0bf6
3a0e03
3a0d04
3a1403
3a15d8
400102
400402
300000
30021c
3004ff
3006c3
300e58
302e00
430061
501f01
471303
440704
440e00
460b35
460c22
483722
382402
5000a7
5001a3
5180ff
5181f2
518200
518314
518425
518524
518609
518709
518809
518988
518a54
518bee
518cb2
518d50
518e34
518f6b
519046
5191f8
519204
519370
5194f0
5195f0
519603
519701
519804
51996c
519a04
519bc0
519c09
519d2b

// File: vlog.f
cam_cfg_pkg.sv
cam_cfg_rom.sv
cam_cfg_seq.sv
ov5640_cfg.sv
tb_sccb_responder.sv
tb_ov5640_cfg.sv
